// File: axi_monitor_vectors.txt
// rst _ AW(ctrl va/rd, id, len) _ W(va/rd/last) _ B(ctrl, id) _ AR(ctrl, id, len) _ R(va/rd/last, id)
// _ expected awr/wr/rd counts _ awr id mask _ rd id mask _ error flags; top digit f ends the list
1_0000_0_00_0000_00_000_00_00_00
// Single-beat write, ID 1, stalled ready on each channel
1_2100_0_00_0000_00_000_00_00_00
1_3100_0_00_0000_00_100_02_00_00
1_0000_5_00_0000_00_100_02_00_00
1_0000_7_00_0000_00_110_02_00_00
1_0000_0_21_0000_00_110_02_00_00
1_0000_0_31_0000_00_000_00_00_00
// Four-beat read, ID 2
1_0000_0_00_3203_00_001_00_04_00
1_0000_0_00_0000_62_001_00_04_00
1_0000_0_00_0000_42_001_00_04_00
1_0000_0_00_0000_62_001_00_04_00
1_0000_0_00_0000_62_001_00_04_00
1_0000_0_00_0000_72_000_00_00_00
// Four-beat write ID 3 alongside a single-beat read ID 5
1_3303_0_00_3500_00_101_08_20_00
1_0000_6_00_0000_75_100_08_00_00
1_0000_4_00_0000_00_100_08_00_00
1_0000_6_00_0000_00_100_08_00_00
1_0000_6_00_0000_00_100_08_00_00
1_0000_7_00_0000_00_110_08_00_00
1_0000_0_33_0000_00_000_00_00_00
// ID reuse, then B on an idle ID with nothing outstanding
1_3400_0_00_0000_00_100_10_00_00
1_3400_7_00_0000_00_210_10_00_04
1_0000_7_00_0000_00_220_10_00_04
1_0000_0_34_0000_00_110_00_00_04
1_0000_0_34_0000_00_000_00_00_0c
1_0000_0_36_0000_00_000_00_00_0e
0_0000_0_00_0000_00_000_00_00_00
// Write one beat short, read one beat long
1_3003_0_00_0000_00_100_01_00_00
1_0000_6_00_0000_00_100_01_00_00
1_0000_6_00_0000_00_100_01_00_00
1_0000_7_00_0000_00_110_01_00_10
1_0000_0_30_0000_00_000_00_00_10
1_0000_0_00_3101_00_001_00_02_10
1_0000_0_00_0000_61_001_00_02_10
1_0000_0_00_0000_61_001_00_02_10
1_0000_0_00_0000_71_000_00_00_30
// Reads on IDs 2 and 3 interleaved mid-burst
1_0000_0_00_3201_00_001_00_04_30
1_0000_0_00_3301_00_002_00_0c_30
1_0000_0_00_0000_62_002_00_0c_30
1_0000_0_00_0000_63_002_00_0c_70
1_0000_0_00_0000_73_001_00_04_70
1_0000_0_00_0000_72_000_00_00_70
0_0000_0_00_0000_00_000_00_00_00
// Seven reads without data, counter overflow, reset clears it
1_0000_0_00_3000_00_001_00_01_00
1_0000_0_00_3100_00_002_00_03_00
1_0000_0_00_3200_00_003_00_07_00
1_0000_0_00_3300_00_004_00_0f_00
1_0000_0_00_3400_00_005_00_1f_00
1_0000_0_00_3500_00_006_00_3f_00
1_0000_0_00_3600_00_007_00_7f_01
1_0000_0_00_0000_00_007_00_7f_01
0_0000_0_00_0000_00_000_00_00_00
1_0000_0_00_0000_00_000_00_00_00
f_0000_0_00_0000_00_000_00_00_00

// File: compile.f
+incdir+.
axi_mon_pkg.sv
axi_txn_counter.sv
axi_id_tracker.sv
axi_burst_checker.sv
axi_master_monitor.sv
axi_monitor_props.sv
tb_axi_master_monitor.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := tb_axi_master_monitor
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100
FAIL_MSG  := Simulation FAILED
PASS_MSG  := Simulation PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run ended without a pass line, see $(LOG)"; exit 1; \
	else \
		echo "Run passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_axi_master_monitor.sv
// Vector-driven testbench for the AXI master monitor
`default_nettype none

module tb_axi_master_monitor;
	timeunit 1ns;
	timeprecision 1ps;

	import axi_mon_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int RST_CYCLES = 3;
	localparam int DRIVE_DELAY = 2;	// After the rising edge
	localparam int TIMEOUT_MARGIN = 10;
	localparam int VEC_MAX = 128;
	localparam int VEC_W = 92;	// 23 hex digits per line

	logic		i_clk;
	logic		i_axi_reset_n;
	logic		i_axi_awvalid;
	logic		i_axi_awready;
	axi_id_t	i_axi_awid;
	burst_len_t	i_axi_awlen;
	logic		i_axi_wvalid;
	logic		i_axi_wready;
	logic		i_axi_wlast;
	logic		i_axi_bvalid;
	logic		i_axi_bready;
	axi_id_t	i_axi_bid;
	logic		i_axi_arvalid;
	logic		i_axi_arready;
	axi_id_t	i_axi_arid;
	burst_len_t	i_axi_arlen;
	logic		i_axi_rvalid;
	logic		i_axi_rready;
	axi_id_t	i_axi_rid;
	logic		i_axi_rlast;

	out_count_t	o_awr_outstanding;
	out_count_t	o_wr_outstanding;
	out_count_t	o_rd_outstanding;
	id_mask_t	o_awr_id_outstanding;
	id_mask_t	o_rd_id_outstanding;
	mon_err_t	o_err_flags;

	logic [VEC_W-1:0]	vectors [0:VEC_MAX-1];	// Inputs then expected outputs
	int		n_vec;
	int		checks_done;
	int		mismatches;
	int		other_errors;
	int		prop_fails;
	int		cycle_count;
	int		cycle_limit;	// Zero until the vectors are counted

	axi_master_monitor DUT
	(
		.i_clk			(i_clk),
		.i_axi_reset_n		(i_axi_reset_n),
		.i_axi_awvalid		(i_axi_awvalid),
		.i_axi_awready		(i_axi_awready),
		.i_axi_awid		(i_axi_awid),
		.i_axi_awlen		(i_axi_awlen),
		.i_axi_wvalid		(i_axi_wvalid),
		.i_axi_wready		(i_axi_wready),
		.i_axi_wlast		(i_axi_wlast),
		.i_axi_bvalid		(i_axi_bvalid),
		.i_axi_bready		(i_axi_bready),
		.i_axi_bid		(i_axi_bid),
		.i_axi_arvalid		(i_axi_arvalid),
		.i_axi_arready		(i_axi_arready),
		.i_axi_arid		(i_axi_arid),
		.i_axi_arlen		(i_axi_arlen),
		.i_axi_rvalid		(i_axi_rvalid),
		.i_axi_rready		(i_axi_rready),
		.i_axi_rid		(i_axi_rid),
		.i_axi_rlast		(i_axi_rlast),
		.o_awr_outstanding	(o_awr_outstanding),
		.o_wr_outstanding	(o_wr_outstanding),
		.o_rd_outstanding	(o_rd_outstanding),
		.o_awr_id_outstanding	(o_awr_id_outstanding),
		.o_rd_id_outstanding	(o_rd_id_outstanding),
		.o_err_flags		(o_err_flags)
	);

	////////////////////////////////////////////////////////////
	// Clock and cycle limit
	////////////////////////////////////////////////////////////

	initial
	begin
		i_clk = 1'b0;
		forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
	end

	always @(posedge i_clk)
	begin
		cycle_count = cycle_count + 1;
		if ((cycle_limit != 0) && (cycle_count >= cycle_limit))
		begin
			$display("Timeout after %0d cycles, the vectors did not finish", cycle_count);
			$display("Simulation FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Vector handling
	////////////////////////////////////////////////////////////

	// Unpack one line onto the bus in the vector file's field layout
	task automatic apply_vector(input int idx);
		logic [VEC_W-1:0] v;
		v = vectors[idx];
		i_axi_reset_n = v[88];
		i_axi_awvalid = v[85];
		i_axi_awready = v[84];
		i_axi_awid = v[82:80];
		i_axi_awlen = v[79:72];
		i_axi_wvalid = v[70];
		i_axi_wready = v[69];
		i_axi_wlast = v[68];
		i_axi_bvalid = v[65];
		i_axi_bready = v[64];
		i_axi_bid = v[62:60];
		i_axi_arvalid = v[57];
		i_axi_arready = v[56];
		i_axi_arid = v[54:52];
		i_axi_arlen = v[51:44];
		i_axi_rvalid = v[42];
		i_axi_rready = v[41];
		i_axi_rid = v[38:36];
		i_axi_rlast = v[40];
	endtask

	task automatic compare_field(input string name, input logic [7:0] got,
			input logic [7:0] exp, input int idx);
		checks_done++;
		if (got !== exp)
		begin
			mismatches++;
			$display("mismatch at %0t: vector %0d, %s is %0h, expected %0h",
					$time, idx, name, got, exp);
		end
	endtask

	// Outputs one cycle after the vector was driven
	task automatic check_outputs(input int idx);
		logic [VEC_W-1:0] v;
		v = vectors[idx];
		compare_field("awr_outstanding", {5'd0, o_awr_outstanding}, {4'd0, v[35:32]}, idx);
		compare_field("wr_outstanding", {5'd0, o_wr_outstanding}, {4'd0, v[31:28]}, idx);
		compare_field("rd_outstanding", {5'd0, o_rd_outstanding}, {4'd0, v[27:24]}, idx);
		compare_field("awr_id_outstanding", o_awr_id_outstanding, v[23:16], idx);
		compare_field("rd_id_outstanding", o_rd_id_outstanding, v[15:8], idx);
		compare_field("err_flags", {1'b0, o_err_flags}, v[7:0], idx);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		logic found_end;

		i_axi_reset_n = 1'b0;	// Held low for the first edges
		i_axi_awvalid = 1'b0;
		i_axi_awready = 1'b0;
		i_axi_awid = '0;
		i_axi_awlen = '0;
		i_axi_wvalid = 1'b0;
		i_axi_wready = 1'b0;
		i_axi_wlast = 1'b0;
		i_axi_bvalid = 1'b0;
		i_axi_bready = 1'b0;
		i_axi_bid = '0;
		i_axi_arvalid = 1'b0;
		i_axi_arready = 1'b0;
		i_axi_arid = '0;
		i_axi_arlen = '0;
		i_axi_rvalid = 1'b0;
		i_axi_rready = 1'b0;
		i_axi_rid = '0;
		i_axi_rlast = 1'b0;
		checks_done = 0;
		mismatches = 0;
		other_errors = 0;
		prop_fails = 0;
		cycle_count = 0;
		cycle_limit = 0;

		$readmemh("axi_monitor_vectors.txt", vectors);

		// Count lines up to the end marker whose top digit is f
		n_vec = 0;
		found_end = 1'b0;
		for (int i = 0; i < VEC_MAX; i++)
		begin
			if (!found_end)
			begin
				if (vectors[i][91:88] == 4'hf)
					found_end = 1'b1;
				else
					n_vec++;
			end
		end
		if (!found_end)
		begin
			other_errors++;
			$display("The vector file has no end marker line");
		end
		cycle_limit = RST_CYCLES + n_vec + TIMEOUT_MARGIN;

		repeat (RST_CYCLES) @(posedge i_clk);
		#DRIVE_DELAY;
		if (n_vec > 0)
			apply_vector(0);
		for (int i = 1; i < n_vec; i++)
		begin
			@(posedge i_clk);
			#DRIVE_DELAY;
			check_outputs(i - 1);	// Previous line has settled
			apply_vector(i);
		end
		if (n_vec > 0)
		begin
			@(posedge i_clk);
			#DRIVE_DELAY;
			check_outputs(n_vec - 1);
		end
		else
		begin
			other_errors++;
			$display("No test vectors were read");
		end

		prop_fails = DUT.u_props.fail_count;	// Bound assertion failures
		$display("Checks: %0d, mismatches: %0d, assertion failures: %0d, other errors: %0d",
				checks_done, mismatches, prop_fails, other_errors);
		if ((mismatches == 0) && (prop_fails == 0) && (other_errors == 0))
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: axi_monitor_props.sv
// Concurrent assertions on the AXI master monitor outputs, bound to its top level
`default_nettype none

module axi_monitor_props
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,
	input	axi_mon_pkg::out_count_t	i_awr_outstanding,
	input	axi_mon_pkg::out_count_t	i_wr_outstanding,
	input	axi_mon_pkg::out_count_t	i_rd_outstanding,
	input	axi_mon_pkg::id_mask_t	i_awr_id_outstanding,
	input	axi_mon_pkg::id_mask_t	i_rd_id_outstanding,
	input	axi_mon_pkg::mon_err_t	i_err_flags
);
	timeunit 1ns;
	timeprecision 1ps;

	import axi_mon_pkg::*;

	localparam out_count_t CNT_ONE = out_count_t'(1);

	int	fail_count = 0;	// Read by the testbench at the end

	// Counter moved by one step or not at all
	function automatic logic step_ok(input out_count_t prev, input out_count_t cur);
		return (cur == prev) || (cur == out_count_t'(prev + CNT_ONE))
				|| (prev == out_count_t'(cur + CNT_ONE));
	endfunction

	////////////////////////////////////////////////////////////
	// Reset and sticky flags
	////////////////////////////////////////////////////////////

	a_reset_clears: assert property (@(posedge i_clk) !i_axi_reset_n |=>
			((i_awr_outstanding == '0) && (i_wr_outstanding == '0)
			&& (i_rd_outstanding == '0) && (i_awr_id_outstanding == '0)
			&& (i_rd_id_outstanding == '0) && (i_err_flags == '0)))
		else
		begin
			fail_count = fail_count + 1;
			$error("Monitor outputs not cleared after reset");
		end

	a_err_sticky: assert property (@(posedge i_clk) i_axi_reset_n |=>
			((i_err_flags & $past(i_err_flags)) == $past(i_err_flags)))
		else
		begin
			fail_count = fail_count + 1;
			$error("An error flag dropped without reset");
		end

	////////////////////////////////////////////////////////////
	// Counter steps
	////////////////////////////////////////////////////////////

	a_awr_step: assert property (@(posedge i_clk) i_axi_reset_n |=>
			step_ok($past(i_awr_outstanding), i_awr_outstanding))
		else
		begin
			fail_count = fail_count + 1;
			$error("Write address counter jumped by more than one");
		end

	a_wr_step: assert property (@(posedge i_clk) i_axi_reset_n |=>
			step_ok($past(i_wr_outstanding), i_wr_outstanding))
		else
		begin
			fail_count = fail_count + 1;
			$error("Write data counter jumped by more than one");
		end

	a_rd_step: assert property (@(posedge i_clk) i_axi_reset_n |=>
			step_ok($past(i_rd_outstanding), i_rd_outstanding))
		else
		begin
			fail_count = fail_count + 1;
			$error("Read counter jumped by more than one");
		end

endmodule

bind axi_master_monitor axi_monitor_props u_props
(
	.i_clk			(i_clk),
	.i_axi_reset_n		(i_axi_reset_n),
	.i_awr_outstanding	(o_awr_outstanding),
	.i_wr_outstanding	(o_wr_outstanding),
	.i_rd_outstanding	(o_rd_outstanding),
	.i_awr_id_outstanding	(o_awr_id_outstanding),
	.i_rd_id_outstanding	(o_rd_id_outstanding),
	.i_err_flags		(o_err_flags)
);

`default_nettype wire

// File: axi_master_monitor.sv
// Passive AXI master-side monitor: burst counters, ID bitmaps, protocol error flags
`default_nettype none

`include "axi_mon_defs.svh"

module axi_master_monitor
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,
	// Write address
	input	wire			i_axi_awvalid,
	input	wire			i_axi_awready,
	input	axi_mon_pkg::axi_id_t	i_axi_awid,
	input	axi_mon_pkg::burst_len_t	i_axi_awlen,
	// Write data
	input	wire			i_axi_wvalid,
	input	wire			i_axi_wready,
	input	wire			i_axi_wlast,
	// Write response
	input	wire			i_axi_bvalid,
	input	wire			i_axi_bready,
	input	axi_mon_pkg::axi_id_t	i_axi_bid,
	// Read address
	input	wire			i_axi_arvalid,
	input	wire			i_axi_arready,
	input	axi_mon_pkg::axi_id_t	i_axi_arid,
	input	axi_mon_pkg::burst_len_t	i_axi_arlen,
	// Read data
	input	wire			i_axi_rvalid,
	input	wire			i_axi_rready,
	input	axi_mon_pkg::axi_id_t	i_axi_rid,
	input	wire			i_axi_rlast,
	// Monitor results
	output	axi_mon_pkg::out_count_t	o_awr_outstanding,
	output	axi_mon_pkg::out_count_t	o_wr_outstanding,
	output	axi_mon_pkg::out_count_t	o_rd_outstanding,
	output	axi_mon_pkg::id_mask_t	o_awr_id_outstanding,
	output	axi_mon_pkg::id_mask_t	o_rd_id_outstanding,
	output	axi_mon_pkg::mon_err_t	o_err_flags
);

	////////////////////////////////////////////////////////////
	// Handshake strobes, the only view children get of the bus
	////////////////////////////////////////////////////////////

	logic	aw_fire;
	logic	w_fire;
	logic	b_fire;
	logic	ar_fire;
	logic	r_fire;

	assign aw_fire = i_axi_awvalid && i_axi_awready;
	assign w_fire = i_axi_wvalid && i_axi_wready;
	assign b_fire = i_axi_bvalid && i_axi_bready;
	assign ar_fire = i_axi_arvalid && i_axi_arready;
	assign r_fire = i_axi_rvalid && i_axi_rready;

	logic	awr_ovf, wr_ovf, rd_ovf;	// Per-counter overflow
	logic	awr_udf, wr_udf, rd_udf;	// Per-counter underflow
	logic	id_reuse, id_unknown;
	logic	wr_len_err, rd_len_err, rd_ilv_err;

	////////////////////////////////////////////////////////////
	// Outstanding burst counters
	////////////////////////////////////////////////////////////

	axi_txn_counter u_awr_cnt	// AW accepted, B retires
	(
		.i_clk		(i_clk),
		.i_axi_reset_n	(i_axi_reset_n),
		.i_inc		(aw_fire),
		.i_dec		(b_fire),
		.o_count	(o_awr_outstanding),
		.o_overflow	(awr_ovf),
		.o_underflow	(awr_udf)
	);

	axi_txn_counter u_wr_cnt	// Whole write bursts of data
	(
		.i_clk		(i_clk),
		.i_axi_reset_n	(i_axi_reset_n),
		.i_inc		(w_fire && i_axi_wlast),
		.i_dec		(b_fire),
		.o_count	(o_wr_outstanding),
		.o_overflow	(wr_ovf),
		.o_underflow	(wr_udf)
	);

	axi_txn_counter u_rd_cnt
	(
		.i_clk		(i_clk),
		.i_axi_reset_n	(i_axi_reset_n),
		.i_inc		(ar_fire),
		.i_dec		(r_fire && i_axi_rlast),	// Last beat closes the burst
		.o_count	(o_rd_outstanding),
		.o_overflow	(rd_ovf),
		.o_underflow	(rd_udf)
	);

	// ID bookkeeping
	axi_id_tracker u_id_trk
	(
		.i_clk			(i_clk),
		.i_axi_reset_n		(i_axi_reset_n),
		.i_aw_fire		(aw_fire),
		.i_ar_fire		(ar_fire),
		.i_b_fire		(b_fire),
		.i_r_fire		(r_fire),
		.i_rlast		(i_axi_rlast),
		.i_awid			(i_axi_awid),
		.i_arid			(i_axi_arid),
		.i_bid			(i_axi_bid),
		.i_rid			(i_axi_rid),
		.o_awr_id_outstanding	(o_awr_id_outstanding),
		.o_rd_id_outstanding	(o_rd_id_outstanding),
		.o_id_reuse		(id_reuse),
		.o_id_unknown		(id_unknown)
	);

	axi_burst_checker u_burst_chk
	(
		.i_clk			(i_clk),
		.i_axi_reset_n		(i_axi_reset_n),
		.i_aw_fire		(aw_fire),
		.i_w_fire		(w_fire),
		.i_ar_fire		(ar_fire),
		.i_r_fire		(r_fire),
		.i_wlast		(i_axi_wlast),
		.i_rlast		(i_axi_rlast),
		.i_awlen		(i_axi_awlen),
		.i_arlen		(i_axi_arlen),
		.i_arid			(i_axi_arid),
		.i_rid			(i_axi_rid),
		.o_wr_len_err		(wr_len_err),
		.o_rd_len_err		(rd_len_err),
		.o_rd_interleave_err	(rd_ilv_err)
	);

	////////////////////////////////////////////////////////////
	// Error vector, every source is already sticky
	////////////////////////////////////////////////////////////

	always_comb
	begin
		o_err_flags[`ERR_CNT_OVERFLOW] = awr_ovf || wr_ovf || rd_ovf;
		o_err_flags[`ERR_RESP_NO_REQ] = awr_udf || wr_udf || rd_udf;
		o_err_flags[`ERR_ID_REUSE] = id_reuse;
		o_err_flags[`ERR_ID_UNKNOWN] = id_unknown;
		o_err_flags[`ERR_WR_BURST_LEN] = wr_len_err;
		o_err_flags[`ERR_RD_BURST_LEN] = rd_len_err;
		o_err_flags[`ERR_RD_INTERLEAVE] = rd_ilv_err;
	end

endmodule

`default_nettype wire

// File: axi_burst_checker.sv
// AXI burst length checks for writes and reads plus read interleave check
`default_nettype none

`include "axi_mon_defs.svh"

module axi_burst_checker
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,
	input	wire			i_aw_fire,
	input	wire			i_w_fire,
	input	wire			i_ar_fire,
	input	wire			i_r_fire,
	input	wire			i_wlast,
	input	wire			i_rlast,
	input	axi_mon_pkg::burst_len_t	i_awlen,
	input	axi_mon_pkg::burst_len_t	i_arlen,
	input	axi_mon_pkg::axi_id_t	i_arid,
	input	axi_mon_pkg::axi_id_t	i_rid,
	output	logic			o_wr_len_err,
	output	logic			o_rd_len_err,
	output	logic			o_rd_interleave_err
);
	import axi_mon_pkg::*;

	////////////////////////////////////////////////////////////
	// Write side
	////////////////////////////////////////////////////////////

	wr_burst_state_t	wr_state_q;
	beat_total_t		wr_total_q;	// Beats promised by held AW
	beat_total_t		wr_count_q;	// Beats before the current one
	logic			wr_len_err_q;

	logic			w_last_fire;
	beat_total_t		wr_beats;	// Including this beat
	beat_total_t		aw_total;
	logic			wr_len_bad;

	assign w_last_fire = i_w_fire && i_wlast;
	assign wr_beats = wr_count_q + 1'b1;
	assign aw_total = beat_total_t'(i_awlen) + 1'b1;

	always_comb
	begin
		wr_len_bad = 1'b0;
		if (wr_state_q == WB_ADDR_HELD)
		begin
			// Second address only if the held burst ends now
			if (i_aw_fire && !w_last_fire)
				wr_len_bad = 1'b1;
			if (w_last_fire && (wr_beats != wr_total_q))
				wr_len_bad = 1'b1;
		end
		else if (w_last_fire)
		begin
			// Nothing held, must be a single beat with its own AW
			if (!(i_aw_fire && (i_awlen == '0) && (wr_count_q == '0)))
				wr_len_bad = 1'b1;
		end
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			wr_state_q <= WB_IDLE;
			wr_count_q <= '0;
			wr_len_err_q <= 1'b0;
		end
		else
		begin
			case (wr_state_q)
				WB_IDLE:
					if (i_aw_fire && !w_last_fire)
						wr_state_q <= WB_ADDR_HELD;
				WB_ADDR_HELD:
					if (w_last_fire && !i_aw_fire)
						wr_state_q <= WB_IDLE;	// Burst done, none queued
				default:
					wr_state_q <= WB_IDLE;
			endcase

			if (w_last_fire)
				wr_count_q <= '0;
			else if (i_w_fire)
				wr_count_q <= wr_beats;

			if (wr_len_bad)
				wr_len_err_q <= 1'b1;
		end
	end

	// Total loads whenever a new address becomes the held one
	always_ff @(posedge i_clk)
	begin
		if (i_aw_fire && ((wr_state_q == WB_IDLE) ? !w_last_fire : w_last_fire))
			wr_total_q <= aw_total;
	end

	////////////////////////////////////////////////////////////
	// Read side
	////////////////////////////////////////////////////////////

	beat_total_t	rd_total_q [0:(1<<`AXI_ID_WIDTH)-1];	// Per-ID promised beats
	beat_total_t	rd_count_q;
	axi_id_t	rd_id_q;	// ID of the burst in progress
	logic		rd_active_q;	// Burst started, last not seen
	logic		rd_len_err_q;
	logic		rd_ilv_err_q;

	beat_total_t	rd_beats;

	assign rd_beats = rd_count_q + 1'b1;

	always_ff @(posedge i_clk)
	begin
		if (i_ar_fire)
			rd_total_q[i_arid] <= beat_total_t'(i_arlen) + 1'b1;
	end

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			rd_count_q <= '0;
			rd_id_q <= '0;
			rd_active_q <= 1'b0;
			rd_len_err_q <= 1'b0;
			rd_ilv_err_q <= 1'b0;
		end
		else if (i_r_fire)
		begin
			rd_id_q <= i_rid;
			rd_active_q <= !i_rlast;
			rd_count_q <= i_rlast ? '0 : rd_beats;

			if (i_rlast && (rd_beats != rd_total_q[i_rid]))
				rd_len_err_q <= 1'b1;	// Short or long read burst
			if (rd_active_q && (i_rid != rd_id_q))
				rd_ilv_err_q <= 1'b1;	// Another ID cut in
		end
	end

	assign o_wr_len_err = wr_len_err_q;
	assign o_rd_len_err = rd_len_err_q;
	assign o_rd_interleave_err = rd_ilv_err_q;

endmodule

`default_nettype wire

// File: axi_id_tracker.sv
// Per-ID outstanding bitmaps for AXI write addresses and reads with ID checks
`default_nettype none

module axi_id_tracker
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,
	input	wire			i_aw_fire,	// AW handshake
	input	wire			i_ar_fire,	// AR handshake
	input	wire			i_b_fire,	// B handshake
	input	wire			i_r_fire,	// R handshake
	input	wire			i_rlast,
	input	axi_mon_pkg::axi_id_t	i_awid,
	input	axi_mon_pkg::axi_id_t	i_arid,
	input	axi_mon_pkg::axi_id_t	i_bid,
	input	axi_mon_pkg::axi_id_t	i_rid,
	output	axi_mon_pkg::id_mask_t	o_awr_id_outstanding,
	output	axi_mon_pkg::id_mask_t	o_rd_id_outstanding,
	output	logic			o_id_reuse,
	output	logic			o_id_unknown
);
	import axi_mon_pkg::*;

	id_mask_t	awr_id_q;	// Write addresses awaiting B
	id_mask_t	rd_id_q;	// Reads awaiting last beat
	logic		reuse_q;
	logic		unknown_q;

	logic		reuse_hit;
	logic		unknown_hit;

	////////////////////////////////////////////////////////////
	// Checks against the bitmaps before this cycle's update
	////////////////////////////////////////////////////////////

	// Issue on an ID that is still busy
	assign reuse_hit = (i_aw_fire && awr_id_q[i_awid])
			|| (i_ar_fire && rd_id_q[i_arid]);

	// Response for an ID nobody asked for, every R beat counts
	assign unknown_hit = (i_b_fire && !awr_id_q[i_bid])
			|| (i_r_fire && !rd_id_q[i_rid]);

	////////////////////////////////////////////////////////////
	// Bitmap update
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			awr_id_q <= '0;
			rd_id_q <= '0;
			reuse_q <= 1'b0;
			unknown_q <= 1'b0;
		end
		else
		begin
			// Set first, clear second, so a clash ends cleared
			if (i_aw_fire)
				awr_id_q[i_awid] <= 1'b1;
			if (i_b_fire)
				awr_id_q[i_bid] <= 1'b0;	// Write fully answered

			if (i_ar_fire)
				rd_id_q[i_arid] <= 1'b1;
			if (i_r_fire && i_rlast)
				rd_id_q[i_rid] <= 1'b0;	// Only the last beat retires

			if (reuse_hit)
				reuse_q <= 1'b1;
			if (unknown_hit)
				unknown_q <= 1'b1;
		end
	end

	assign o_awr_id_outstanding = awr_id_q;
	assign o_rd_id_outstanding = rd_id_q;
	assign o_id_reuse = reuse_q;
	assign o_id_unknown = unknown_q;

endmodule

`default_nettype wire

// File: axi_txn_counter.sv
// Outstanding AXI burst counter with sticky overflow and underflow flags
`default_nettype none

module axi_txn_counter
(
	input	wire			i_clk,
	input	wire			i_axi_reset_n,
	input	wire			i_inc,		// Burst started
	input	wire			i_dec,		// Burst retired
	output	axi_mon_pkg::out_count_t	o_count,
	output	logic			o_overflow,
	output	logic			o_underflow
);
	import axi_mon_pkg::*;

	// Counter saturates here, one below is the last safe value
	localparam out_count_t CNT_FULL = '1;
	localparam out_count_t CNT_NEAR_FULL = CNT_FULL - 1'b1;

	out_count_t	count_q;
	logic		overflow_q;
	logic		underflow_q;

	always_ff @(posedge i_clk)
	begin
		if (!i_axi_reset_n)
		begin
			count_q <= '0;
			overflow_q <= 1'b0;
			underflow_q <= 1'b0;
		end
		else
		begin
			case ({i_inc, i_dec})
				2'b10:
				begin
					if (count_q != CNT_FULL)
						count_q <= count_q + 1'b1;	// Hold at top
					if (count_q >= CNT_NEAR_FULL)
						overflow_q <= 1'b1;	// Reaching all ones
				end
				2'b01:
				begin
					// Retire with nothing open
					if (count_q == '0)
						underflow_q <= 1'b1;
					else
						count_q <= count_q - 1'b1;
				end
				default:
				begin
					// Both or neither, count stays
				end
			endcase
		end
	end

	assign o_count = count_q;
	assign o_overflow = overflow_q;
	assign o_underflow = underflow_q;

endmodule

`default_nettype wire

// File: axi_mon_pkg.sv
// AXI master monitor types shared by the checker blocks and the top
`default_nettype none

`include "axi_mon_defs.svh"

package axi_mon_pkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	typedef logic [`AXI_ID_WIDTH-1:0]		axi_id_t;	// One AXI ID
	typedef logic [(1<<`AXI_ID_WIDTH)-1:0]	id_mask_t;	// Bit per ID
	typedef logic [`AXI_LEN_WIDTH-1:0]		burst_len_t;	// AxLEN or beat count
	typedef logic [`AXI_LEN_WIDTH:0]		beat_total_t;	// AxLEN plus one
	typedef logic [`AXI_ID_WIDTH-1:0]		out_count_t;	// Outstanding bursts
	typedef logic [`ERR_COUNT-1:0]		mon_err_t;	// Sticky error flags

	////////////////////////////////////////////////////////////
	// Write burst tracking
	////////////////////////////////////////////////////////////

	// Only one write address may wait for its data at a time
	typedef enum logic
	{
		WB_IDLE,	// No address waiting
		WB_ADDR_HELD	// One address waiting for its last beat
	} wr_burst_state_t;

endpackage

`default_nettype wire

// File: axi_mon_defs.svh
// AXI master monitor widths and error flag bit positions
`ifndef AXI_MON_DEFS_SVH
`define AXI_MON_DEFS_SVH

////////////////////////////////////////////////////////////
// Bus field widths
////////////////////////////////////////////////////////////

`define AXI_ID_WIDTH	3	// IDs, also sizes the outstanding counters
`define AXI_LEN_WIDTH	8	// AxLEN field

////////////////////////////////////////////////////////////
// Error vector layout
////////////////////////////////////////////////////////////

`define ERR_CNT_OVERFLOW	0	// Any outstanding counter hit all ones
`define ERR_RESP_NO_REQ		1	// Response or last beat with nothing outstanding
`define ERR_ID_REUSE		2	// Address issued on a busy ID
`define ERR_ID_UNKNOWN		3	// B or R on an idle ID
`define ERR_WR_BURST_LEN	4	// Write beats disagree with AWLEN
`define ERR_RD_BURST_LEN	5	// Read beats disagree with ARLEN
`define ERR_RD_INTERLEAVE	6	// Read ID changed inside a burst

`define ERR_COUNT		7

`endif
